/* logic/fpgc_config.svh */
// Build-time constants for the FPGC housekeeping and video-memory logic
// Included by every file that needs a depth, a timer length or a RAM size
// LED hold time is the short simulation value; the board build uses 100000
`ifndef FPGC_CONFIG_SVH
`define FPGC_CONFIG_SVH

// Flops per asynchronous input
`define FPGC_SYNC_STAGES 2

// System reset length after a DTR rising edge, in clk cycles
`define FPGC_DTR_PULSE_CYCLES 8

// Minimum on-time of a stretched activity LED
`define FPGC_LED_HOLD_CYCLES 16

// Video RAM depths in words
`define FPGC_VRAM32_WORDS 1056
`define FPGC_VRAM8_WORDS 8194
`define FPGC_VRAMSPR_WORDS 256

`endif

/* logic/fpgc_sys_pkg.sv */
// Board-side types: asynchronous pins, external reset lines, activity
// sources and the status LED group
// Referenced by scoped name from the top level and the housekeeping blocks
package fpgc_sys_pkg;

    // Raw pins and their synchronized copy share this layout
    typedef struct packed {
        logic btn_l_n;
        logic btn_r_n;
        logic uart0_dtr;
        logic spi1_nint;
        logic spi2_nint;
        logic spi3_int;
        logic spi4_gp;
        logic frame_drawn;
        logic boot_mode;
    } async_in_t;

    // Stable interrupt and boot bits for the CPU side
    typedef struct packed {
        logic spi1_nint;
        logic spi2_nint;
        logic spi3_int;
        logic spi4_gp;
        logic frame_drawn;
        logic boot_mode;
    } irq_t;

    // USB chips reset high, Ethernet chip reset low
    typedef struct packed {
        logic usb0_rst;
        logic usb1_rst;
        logic eth_nrst;
    } ext_reset_t;

    // Active-high bus activity
    typedef struct packed {
        logic flash;
        logic usb0;
        logic usb1;
        logic eth;
        logic ps2;
    } activity_t;

    typedef struct packed {
        logic dtr;
        logic flash;
        logic usb0;
        logic usb1;
        logic eth;
        logic ps2;
        logic gpu;
    } status_led_t;

endpackage

/* logic/fpgc_video_pkg.sv */
// Video RAM types: word, address and CPU request for each of the three RAMs
// Address widths follow the RAM depths in the config header
`include "fpgc_config.svh"

package fpgc_video_pkg;

    // Word widths
    typedef logic [31:0] vram32_word_t;
    typedef logic [7:0]  vram8_word_t;
    typedef logic [8:0]  vramspr_word_t;

    // Just wide enough for each depth
    typedef logic [$clog2(`FPGC_VRAM32_WORDS)-1:0]  vram32_addr_t;
    typedef logic [$clog2(`FPGC_VRAM8_WORDS)-1:0]   vram8_addr_t;
    typedef logic [$clog2(`FPGC_VRAMSPR_WORDS)-1:0] vramspr_addr_t;

    // CPU port requests, one per cycle, no handshake
    typedef struct packed {
        logic         we;
        vram32_addr_t addr;
        vram32_word_t data;
    } vram32_req_t;

    typedef struct packed {
        logic        we;
        vram8_addr_t addr;
        vram8_word_t data;
    } vram8_req_t;

    typedef struct packed {
        logic          we;
        vramspr_addr_t addr;
        vramspr_word_t data;
    } vramspr_req_t;

endpackage

/* logic/multi_stabilizer.sv */
// Synchronizer for the whole group of asynchronous board inputs
// Every bit passes the same register chain, so all see the same delay
`timescale 1ns/1ns
`include "fpgc_config.svh"

module multi_stabilizer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fpgc_sys_pkg::async_in_t async_in,
    output fpgc_sys_pkg::async_in_t stable
);

    localparam int STAGES = `FPGC_SYNC_STAGES;

    // Stage 0 may go metastable, later stages settle it
    fpgc_sys_pkg::async_in_t sync_q [STAGES];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= async_in;
            // Shift toward the output
            for (int i = 1; i < STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // Last stage is the clean copy
    assign stable = sync_q[STAGES-1];

endmodule

/* logic/reset_gen.sv */
// System reset from the reset buttons and from a UART0 DTR rising edge
// Host opening the serial port gives a fixed-length reset pulse
// Also drives the reset lines of the two USB chips and the Ethernet chip
`timescale 1ns/1ns
`include "fpgc_config.svh"

module reset_gen (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     btn_l_n,
    input  logic                     btn_r_n,
    input  logic                     dtr,
    output logic                     sys_reset,
    output fpgc_sys_pkg::ext_reset_t ext_reset
);

    localparam int PULSE    = `FPGC_DTR_PULSE_CYCLES;
    localparam int CNT_BITS = $clog2(PULSE + 1);

    logic                dtr_q;
    logic [CNT_BITS-1:0] pulse_cnt;
    logic                dtr_rise;
    logic                btn_hold;

    // Low one cycle, high the next
    assign dtr_rise = dtr & ~dtr_q;

    // Either button pressed
    assign btn_hold = ~btn_l_n | ~btn_r_n;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dtr_q     <= 1'b0;
            pulse_cnt <= '0;
            sys_reset <= 1'b0;
        end else begin
            dtr_q <= dtr;
            // Edge cycle itself counts as the first pulse cycle
            if (dtr_rise) begin
                pulse_cnt <= CNT_BITS'(PULSE - 1);
            end else if (pulse_cnt != '0) begin
                pulse_cnt <= pulse_cnt - 1'b1;
            end
            sys_reset <= btn_hold | dtr_rise | (pulse_cnt != '0);
        end
    end

    // External chips follow the system reset
    assign ext_reset.usb0_rst = sys_reset;
    assign ext_reset.usb1_rst = sys_reset;
    assign ext_reset.eth_nrst = ~sys_reset;

endmodule

/* logic/activity_led.sv */
// Stretches short bus activity into an LED that stays on long enough to see
// LED follows the activity one cycle later and holds HOLD_CYCLES after it ends
// System reset turns the LED off
`timescale 1ns/1ns
`include "fpgc_config.svh"

module activity_led #(
    parameter int HOLD_CYCLES = `FPGC_LED_HOLD_CYCLES
) (
    input  logic clk,
    input  logic rst_n,
    input  logic sys_reset,
    input  logic activity,
    output logic led
);

    localparam int CNT_BITS = $clog2(HOLD_CYCLES + 1);

    // Remaining hold cycles after the last active cycle
    logic [CNT_BITS-1:0] hold_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_cnt <= '0;
            led      <= 1'b0;
        end else if (sys_reset) begin
            hold_cnt <= '0;
            led      <= 1'b0;
        end else begin
            // Reload while busy, drain once idle
            if (activity) begin
                hold_cnt <= CNT_BITS'(HOLD_CYCLES - 1);
            end else if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
            led <= activity | (hold_cnt != '0);
        end
    end

endmodule

/* logic/vram.sv */
// Dual-port video RAM: CPU read/write port and GPU read-only port
// Word and request layouts come in as type parameters, so one body
// serves every video RAM; both reads are registered, one cycle latency
`timescale 1ns/1ns

module vram #(
    parameter type word_t    = fpgc_video_pkg::vram32_word_t,
    parameter type req_t     = fpgc_video_pkg::vram32_req_t,
    parameter int  WORDS     = 1056,
    parameter int  ADDR_BITS = 11
) (
    input  logic                 clk,
    input  req_t                 cpu_req,
    output word_t                cpu_q,
    input  logic [ADDR_BITS-1:0] gpu_addr,
    output word_t                gpu_q
);

    word_t mem [WORDS];

    logic cpu_in_range;
    logic gpu_in_range;

    // Depth need not be a power of two
    assign cpu_in_range = cpu_req.addr < WORDS;
    assign gpu_in_range = gpu_addr < WORDS;

    // CPU port, read returns the old word on a write to the same address
    always_ff @(posedge clk) begin
        if (cpu_req.we && cpu_in_range) begin
            mem[cpu_req.addr] <= cpu_req.data;
        end
        cpu_q <= cpu_in_range ? mem[cpu_req.addr] : '0;
    end

    // GPU port, read only
    always_ff @(posedge clk) begin
        gpu_q <= gpu_in_range ? mem[gpu_addr] : '0;
    end

endmodule

/* logic/fpgc_platform.sv */
// FPGC board housekeeping and video memory on the system clock
// Synchronizes the board pins, builds the system and external resets,
// holds the three video RAMs and drives the status LEDs
// CPU and GPU sides connect through the request and read ports
`timescale 1ns/1ns
`include "fpgc_config.svh"

module fpgc_platform (
    input  logic                          clk,
    input  logic                          rst_n,
    input  fpgc_sys_pkg::async_in_t       async_in,
    // Order flash, usb0, usb1, eth from msb down
    input  logic [3:0]                    spi_cs_n,
    input  logic                          ps2_int,
    output logic                          sys_reset,
    output fpgc_sys_pkg::ext_reset_t      ext_reset,
    output fpgc_sys_pkg::irq_t            irq,
    input  fpgc_video_pkg::vram32_req_t   vram32_cpu,
    output fpgc_video_pkg::vram32_word_t  vram32_cpu_q,
    input  fpgc_video_pkg::vram32_addr_t  vram32_gpu_addr,
    output fpgc_video_pkg::vram32_word_t  vram32_gpu_q,
    input  fpgc_video_pkg::vram8_req_t    vram8_cpu,
    output fpgc_video_pkg::vram8_word_t   vram8_cpu_q,
    input  fpgc_video_pkg::vram8_addr_t   vram8_gpu_addr,
    output fpgc_video_pkg::vram8_word_t   vram8_gpu_q,
    input  fpgc_video_pkg::vramspr_req_t  vramspr_cpu,
    output fpgc_video_pkg::vramspr_word_t vramspr_cpu_q,
    input  fpgc_video_pkg::vramspr_addr_t vramspr_gpu_addr,
    output fpgc_video_pkg::vramspr_word_t vramspr_gpu_q,
    output fpgc_sys_pkg::status_led_t     status_led
);

    fpgc_sys_pkg::async_in_t stable;
    fpgc_sys_pkg::activity_t activity;
    logic                    gpu_activity;

    multi_stabilizer u_stabilizer (
        .clk      (clk),
        .rst_n    (rst_n),
        .async_in (async_in),
        .stable   (stable)
    );

    reset_gen u_reset_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .btn_l_n   (stable.btn_l_n),
        .btn_r_n   (stable.btn_r_n),
        .dtr       (stable.uart0_dtr),
        .sys_reset (sys_reset),
        .ext_reset (ext_reset)
    );

    // Stable interrupt and boot bits to the CPU side
    assign irq = '{
        spi1_nint:   stable.spi1_nint,
        spi2_nint:   stable.spi2_nint,
        spi3_int:    stable.spi3_int,
        spi4_gp:     stable.spi4_gp,
        frame_drawn: stable.frame_drawn,
        boot_mode:   stable.boot_mode
    };

    vram #(
        .word_t    (fpgc_video_pkg::vram32_word_t),
        .req_t     (fpgc_video_pkg::vram32_req_t),
        .WORDS     (`FPGC_VRAM32_WORDS),
        .ADDR_BITS ($bits(fpgc_video_pkg::vram32_addr_t))
    ) u_vram32 (
        .clk      (clk),
        .cpu_req  (vram32_cpu),
        .cpu_q    (vram32_cpu_q),
        .gpu_addr (vram32_gpu_addr),
        .gpu_q    (vram32_gpu_q)
    );

    vram #(
        .word_t    (fpgc_video_pkg::vram8_word_t),
        .req_t     (fpgc_video_pkg::vram8_req_t),
        .WORDS     (`FPGC_VRAM8_WORDS),
        .ADDR_BITS ($bits(fpgc_video_pkg::vram8_addr_t))
    ) u_vram8 (
        .clk      (clk),
        .cpu_req  (vram8_cpu),
        .cpu_q    (vram8_cpu_q),
        .gpu_addr (vram8_gpu_addr),
        .gpu_q    (vram8_gpu_q)
    );

    vram #(
        .word_t    (fpgc_video_pkg::vramspr_word_t),
        .req_t     (fpgc_video_pkg::vramspr_req_t),
        .WORDS     (`FPGC_VRAMSPR_WORDS),
        .ADDR_BITS ($bits(fpgc_video_pkg::vramspr_addr_t))
    ) u_vramspr (
        .clk      (clk),
        .cpu_req  (vramspr_cpu),
        .cpu_q    (vramspr_cpu_q),
        .gpu_addr (vramspr_gpu_addr),
        .gpu_q    (vramspr_gpu_q)
    );

    // Chip selects are active low; field order matches spi_cs_n
    assign activity = {~spi_cs_n, ps2_int};

    // Any CPU write into video memory
    assign gpu_activity = vram32_cpu.we | vram8_cpu.we | vramspr_cpu.we;

    // Debug LED shows the open serial port directly
    assign status_led.dtr = stable.uart0_dtr;

    activity_led u_led_flash (
        .clk       (clk),
        .rst_n     (rst_n),
        .sys_reset (sys_reset),
        .activity  (activity.flash),
        .led       (status_led.flash)
    );

    activity_led u_led_usb0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .sys_reset (sys_reset),
        .activity  (activity.usb0),
        .led       (status_led.usb0)
    );

    activity_led u_led_usb1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .sys_reset (sys_reset),
        .activity  (activity.usb1),
        .led       (status_led.usb1)
    );

    activity_led u_led_eth (
        .clk       (clk),
        .rst_n     (rst_n),
        .sys_reset (sys_reset),
        .activity  (activity.eth),
        .led       (status_led.eth)
    );

    activity_led u_led_ps2 (
        .clk       (clk),
        .rst_n     (rst_n),
        .sys_reset (sys_reset),
        .activity  (activity.ps2),
        .led       (status_led.ps2)
    );

    activity_led u_led_gpu (
        .clk       (clk),
        .rst_n     (rst_n),
        .sys_reset (sys_reset),
        .activity  (gpu_activity),
        .led       (status_led.gpu)
    );

endmodule

/* bench/tb_fpgc_platform.sv */
// Directed testbench for the FPGC housekeeping and video-memory top level
// Covers reset state, buttons, DTR pulse, interrupt sync, video RAMs, LEDs
// Inputs change 1 ns after the rising edge, outputs are sampled there too
`timescale 1ns/1ns
`include "fpgc_config.svh"

module tb_fpgc_platform;

    // All six tests take well under 1500 cycles
    localparam int MAX_CYCLES = 3000;
    localparam int RAM_WRITES = 16;

    logic                          clk;
    logic                          rst_n;
    fpgc_sys_pkg::async_in_t       async_in;
    logic [3:0]                    spi_cs_n;
    logic                          ps2_int;
    logic                          sys_reset;
    fpgc_sys_pkg::ext_reset_t      ext_reset;
    fpgc_sys_pkg::irq_t            irq;
    fpgc_video_pkg::vram32_req_t   vram32_cpu;
    fpgc_video_pkg::vram32_word_t  vram32_cpu_q;
    fpgc_video_pkg::vram32_addr_t  vram32_gpu_addr;
    fpgc_video_pkg::vram32_word_t  vram32_gpu_q;
    fpgc_video_pkg::vram8_req_t    vram8_cpu;
    fpgc_video_pkg::vram8_word_t   vram8_cpu_q;
    fpgc_video_pkg::vram8_addr_t   vram8_gpu_addr;
    fpgc_video_pkg::vram8_word_t   vram8_gpu_q;
    fpgc_video_pkg::vramspr_req_t  vramspr_cpu;
    fpgc_video_pkg::vramspr_word_t vramspr_cpu_q;
    fpgc_video_pkg::vramspr_addr_t vramspr_gpu_addr;
    fpgc_video_pkg::vramspr_word_t vramspr_gpu_q;
    fpgc_sys_pkg::status_led_t     status_led;

    int unsigned rng_state = 32'h0744_c5d2;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          cycles = 0;

    // Expected contents of the three RAMs
    fpgc_video_pkg::vram32_word_t  model32  [`FPGC_VRAM32_WORDS];
    fpgc_video_pkg::vram8_word_t   model8   [`FPGC_VRAM8_WORDS];
    fpgc_video_pkg::vramspr_word_t modelspr [`FPGC_VRAMSPR_WORDS];

    fpgc_platform u_fpgc_platform (
        .clk              (clk),
        .rst_n            (rst_n),
        .async_in         (async_in),
        .spi_cs_n         (spi_cs_n),
        .ps2_int          (ps2_int),
        .sys_reset        (sys_reset),
        .ext_reset        (ext_reset),
        .irq              (irq),
        .vram32_cpu       (vram32_cpu),
        .vram32_cpu_q     (vram32_cpu_q),
        .vram32_gpu_addr  (vram32_gpu_addr),
        .vram32_gpu_q     (vram32_gpu_q),
        .vram8_cpu        (vram8_cpu),
        .vram8_cpu_q      (vram8_cpu_q),
        .vram8_gpu_addr   (vram8_gpu_addr),
        .vram8_gpu_q      (vram8_gpu_q),
        .vramspr_cpu      (vramspr_cpu),
        .vramspr_cpu_q    (vramspr_cpu_q),
        .vramspr_gpu_addr (vramspr_gpu_addr),
        .vramspr_gpu_q    (vramspr_gpu_q),
        .status_led       (status_led)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run passed %0d cycles before the tests finished", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // One clock, landing just after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(string name, logic [63:0] got, logic [63:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
        end
    endtask

    task automatic end_test(string name, int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic check_resets(logic expected);
        check_value("sys_reset", sys_reset, expected);
        check_value("ext_reset.usb0_rst", ext_reset.usb0_rst, expected);
        check_value("ext_reset.usb1_rst", ext_reset.usb1_rst, expected);
        check_value("ext_reset.eth_nrst", ext_reset.eth_nrst, !expected);
    endtask

    task automatic init_inputs();
        async_in         = '0;
        async_in.btn_l_n = 1'b1;
        async_in.btn_r_n = 1'b1;
        // Chip selects idle deasserted
        spi_cs_n         = 4'hf;
        ps2_int          = 1'b0;
        vram32_cpu       = '0;
        vram8_cpu        = '0;
        vramspr_cpu      = '0;
        vram32_gpu_addr  = '0;
        vram8_gpu_addr   = '0;
        vramspr_gpu_addr = '0;
    endtask

    task automatic test_reset_state();
        int e0;
        e0 = errors;
        check_resets(1'b0);
        check_value("status_led", status_led, '0);
        end_test("reset state", e0);
    endtask

    task automatic press_button(logic left);
        if (left) begin
            async_in.btn_l_n = 1'b0;
        end else begin
            async_in.btn_r_n = 1'b0;
        end
        // Two sync stages, then the reset register
        repeat (2) next_cycle();
        check_resets(1'b0);
        next_cycle();
        check_resets(1'b1);
        repeat (3) next_cycle();
        async_in.btn_l_n = 1'b1;
        async_in.btn_r_n = 1'b1;
        repeat (2) next_cycle();
        check_resets(1'b1);
        next_cycle();
        check_resets(1'b0);
    endtask

    task automatic test_buttons();
        int e0;
        e0 = errors;
        press_button(1'b1);
        press_button(1'b0);
        end_test("buttons", e0);
    endtask

    task automatic test_dtr_pulse();
        int e0;
        e0 = errors;
        async_in.uart0_dtr = 1'b1;
        next_cycle();
        check_value("status_led.dtr", status_led.dtr, 1'b0);
        next_cycle();
        check_value("status_led.dtr", status_led.dtr, 1'b1);
        check_value("sys_reset", sys_reset, 1'b0);
        for (int i = 0; i < `FPGC_DTR_PULSE_CYCLES; i++) begin
            next_cycle();
            check_resets(1'b1);
            check_value("status_led[5:0]", status_led[5:0], '0);
            // Bus activity inside the pulse, the reset keeps every LED dark
            spi_cs_n = 4'h0;
            ps2_int  = 1'b1;
        end
        spi_cs_n = 4'hf;
        ps2_int  = 1'b0;
        // Level still high, pulse must not repeat
        repeat (20) begin
            next_cycle();
            check_resets(1'b0);
        end
        async_in.uart0_dtr = 1'b0;
        repeat (3) next_cycle();
        end_test("dtr pulse", e0);
    endtask

    task automatic test_irq_sync();
        logic [5:0]  pattern [20];
        logic [31:0] r;
        int          e0;
        e0 = errors;
        for (int i = 0; i <= 20; i++) begin
            if (i < 20) begin
                r = next_random();
                pattern[i] = r[5:0];
                // Low six bits are the interrupt and boot fields
                async_in[5:0] = pattern[i];
            end
            next_cycle();
            if (i > 0) begin
                check_value("irq", irq, pattern[i-1]);
            end
        end
        async_in[5:0] = '0;
        repeat (2) next_cycle();
        end_test("irq sync", e0);
    endtask

    task automatic test_vram();
        int unsigned a32  [RAM_WRITES];
        int unsigned a8   [RAM_WRITES];
        int unsigned aspr [RAM_WRITES];
        int unsigned oor32;
        int unsigned oor8;
        int unsigned j;
        logic [31:0] r;
        int          e0;
        e0 = errors;
        // Address 0 is written first, used later by the ignored-write check
        for (int i = 0; i < RAM_WRITES; i++) begin
            a32[i]  = (i == 0) ? 0 : next_random() % `FPGC_VRAM32_WORDS;
            a8[i]   = (i == 0) ? 0 : next_random() % `FPGC_VRAM8_WORDS;
            aspr[i] = (i == 0) ? 0 : next_random() % `FPGC_VRAMSPR_WORDS;
            r = next_random();
            vram32_cpu.we    = 1'b1;
            vram32_cpu.addr  = fpgc_video_pkg::vram32_addr_t'(a32[i]);
            vram32_cpu.data  = r;
            vram8_cpu.we     = 1'b1;
            vram8_cpu.addr   = fpgc_video_pkg::vram8_addr_t'(a8[i]);
            vram8_cpu.data   = r[15:8];
            vramspr_cpu.we   = 1'b1;
            vramspr_cpu.addr = fpgc_video_pkg::vramspr_addr_t'(aspr[i]);
            vramspr_cpu.data = r[24:16];
            model32[a32[i]]   = r;
            model8[a8[i]]     = r[15:8];
            modelspr[aspr[i]] = r[24:16];
            next_cycle();
            check_value("status_led.gpu", status_led.gpu, 1'b1);
        end
        // Out-of-range writes, sprite RAM has no such address
        oor32 = `FPGC_VRAM32_WORDS + next_random() % (2048 - `FPGC_VRAM32_WORDS);
        oor8  = `FPGC_VRAM8_WORDS + next_random() % (16384 - `FPGC_VRAM8_WORDS);
        vram32_cpu.addr = fpgc_video_pkg::vram32_addr_t'(oor32);
        vram32_cpu.data = ~model32[0];
        vram8_cpu.addr  = fpgc_video_pkg::vram8_addr_t'(oor8);
        vram8_cpu.data  = ~model8[0];
        vramspr_cpu.we  = 1'b0;
        next_cycle();
        vram32_cpu.we = 1'b0;
        vram8_cpu.we  = 1'b0;
        // Back-to-back reads, GPU walks the list backwards
        for (int i = 0; i < RAM_WRITES; i++) begin
            j = RAM_WRITES - 1 - i;
            vram32_cpu.addr  = fpgc_video_pkg::vram32_addr_t'(a32[i]);
            vram32_gpu_addr  = fpgc_video_pkg::vram32_addr_t'(a32[j]);
            vram8_cpu.addr   = fpgc_video_pkg::vram8_addr_t'(a8[i]);
            vram8_gpu_addr   = fpgc_video_pkg::vram8_addr_t'(a8[j]);
            vramspr_cpu.addr = fpgc_video_pkg::vramspr_addr_t'(aspr[i]);
            vramspr_gpu_addr = fpgc_video_pkg::vramspr_addr_t'(aspr[j]);
            next_cycle();
            check_value("vram32_cpu_q", vram32_cpu_q, model32[a32[i]]);
            check_value("vram32_gpu_q", vram32_gpu_q, model32[a32[j]]);
            check_value("vram8_cpu_q", vram8_cpu_q, model8[a8[i]]);
            check_value("vram8_gpu_q", vram8_gpu_q, model8[a8[j]]);
            check_value("vramspr_cpu_q", vramspr_cpu_q, modelspr[aspr[i]]);
            check_value("vramspr_gpu_q", vramspr_gpu_q, modelspr[aspr[j]]);
        end
        vram32_cpu.addr = fpgc_video_pkg::vram32_addr_t'(oor32);
        vram32_gpu_addr = fpgc_video_pkg::vram32_addr_t'(oor32);
        vram8_cpu.addr  = fpgc_video_pkg::vram8_addr_t'(oor8);
        vram8_gpu_addr  = fpgc_video_pkg::vram8_addr_t'(oor8);
        next_cycle();
        check_value("vram32_cpu_q", vram32_cpu_q, '0);
        check_value("vram32_gpu_q", vram32_gpu_q, '0);
        check_value("vram8_cpu_q", vram8_cpu_q, '0);
        check_value("vram8_gpu_q", vram8_gpu_q, '0);
        vram32_cpu.addr = '0;
        vram8_cpu.addr  = '0;
        next_cycle();
        check_value("vram32_cpu_q", vram32_cpu_q, model32[0]);
        check_value("vram8_cpu_q", vram8_cpu_q, model8[0]);
        end_test("video rams", e0);
    endtask

    // LED bits: dtr flash usb0 usb1 eth ps2 gpu, msb first
    task automatic stretch_pulse(logic [3:0] cs_n, logic ps2, logic [6:0] led_mask);
        spi_cs_n = cs_n;
        ps2_int  = ps2;
        next_cycle();
        spi_cs_n = 4'hf;
        ps2_int  = 1'b0;
        check_value("status_led", status_led, led_mask);
        for (int i = 2; i <= `FPGC_LED_HOLD_CYCLES; i++) begin
            next_cycle();
            check_value("status_led", status_led, led_mask);
        end
        next_cycle();
        check_value("status_led", status_led, '0);
    endtask

    task automatic test_activity();
        int e0;
        e0 = errors;
        // gpu LED from the RAM writes drains first
        repeat (`FPGC_LED_HOLD_CYCLES + 4) next_cycle();
        check_value("status_led", status_led, '0);
        stretch_pulse(4'b1011, 1'b0, 7'b001_0000);
        stretch_pulse(4'b1111, 1'b1, 7'b000_0010);
        end_test("activity stretch", e0);
    endtask

    initial begin
        init_inputs();
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Stabilizer starts with buttons at zero
        repeat (4) next_cycle();
        test_reset_state();
        test_buttons();
        test_dtr_pulse();
        test_irq_sync();
        test_vram();
        test_activity();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+logic
logic/fpgc_sys_pkg.sv
logic/fpgc_video_pkg.sv
logic/multi_stabilizer.sv
logic/reset_gen.sv
logic/activity_led.sv
logic/vram.sv
logic/fpgc_platform.sv
bench/tb_fpgc_platform.sv

/* Makefile */
TOP := tb_fpgc_platform
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module $(TOP) -Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf $(OBJ) sim.log
